//--- rtl/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

////////////////////////////////////////
// fetch width
////////////////////////////////////////

`define FETCH_NUM_SLOTS  2            // instructions per 64-bit fetch word

////////////////////////////////////////
// storage sizes
////////////////////////////////////////

`define FETCH_BUF_DEPTH  4            // fetch packets held ahead of decode
`define FETCH_BP_ENTRIES 64           // bimodal counters, must be a power of two

////////////////////////////////////////
// constants
////////////////////////////////////////

// addi x0,x0,0 placed in slots that carry no real instruction
`define FETCH_NOP_INST   32'h0000_0013
`define FETCH_RESET_PC   64'h0        // first fetch address out of reset

`endif

//--- rtl/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

  ////////////////////////////////////////
  // fetch packet
  ////////////////////////////////////////

  // one instruction slot as handed to decode
  typedef struct packed {
    logic [63:0] pc;          // address of this instruction
    logic [63:0] npc;         // pc + 4
    logic [31:0] inst;        // raw encoding or nop
    logic [63:0] target;      // predicted next pc
    logic        pred_taken;  // predicted to redirect
    logic        valid;       // slot holds a real instruction
  } fetch_slot_t;

  // whole fetch word, slot 0 at the lower address
  typedef fetch_slot_t [`FETCH_NUM_SLOTS-1:0] fetch_packet_t;

  ////////////////////////////////////////
  // predecode and prediction
  ////////////////////////////////////////

  typedef struct packed {
    logic        is_branch;   // conditional branch opcode
    logic        is_jal;      // direct jump
    logic [63:0] target;      // pc + b or j immediate
  } predecode_t;

  // direction per slot from the counter msb
  typedef struct packed {
    logic [`FETCH_NUM_SLOTS-1:0] taken;
  } bp_lookup_t;

  // branch outcome coming back from execute
  typedef struct packed {
    logic        valid;
    logic [63:0] pc;
    logic        taken;
  } bp_resolve_t;

  // back end redirect
  typedef struct packed {
    logic        en;
    logic [63:0] pc;
  } rollback_t;

endpackage

//--- rtl/fetch_stage.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_stage (
  input  logic                                         clock,
  input  logic                                         reset,
  output logic [63:0]                                  imem_addr,   // 8-byte aligned
  input  logic [63:0]                                  imem_data,
  input  logic                                         imem_valid,
  input  fetch_pkg::rollback_t                         rollback,
  output logic [`FETCH_NUM_SLOTS-1:0][63:0]            slot_pc,
  output logic [63:0]                                  slot_word,   // raw word for predecode
  input  fetch_pkg::predecode_t [`FETCH_NUM_SLOTS-1:0] pdec,
  input  fetch_pkg::bp_lookup_t                        bp_taken,
  input  logic                                         buf_full,
  output logic                                         push,
  output fetch_pkg::fetch_packet_t                     push_packet
);

  logic [63:0]                 pc_reg;       // current fetch pc, bit 2 may be set
  logic [63:0]                 pc_base;      // aligned word address
  logic [63:0]                 pc_seq;       // next sequential word
  logic [63:0]                 redirect_pc;  // first taken target or pc_seq
  logic [63:0]                 next_pc;
  logic                        pc_en;
  logic                        blocked;      // an earlier slot already redirects
  logic [`FETCH_NUM_SLOTS-1:0] slot_taken;   // raw prediction before masking
  logic [`FETCH_NUM_SLOTS-1:0] slot_valid;

  ////////////////////////////////////////
  // addresses
  ////////////////////////////////////////

  assign pc_base   = {pc_reg[63:3], 3'b000};
  assign pc_seq    = pc_base + 64'd8;
  assign imem_addr = pc_base;
  assign slot_word = imem_data;  // predecode splits it per slot

  // slot pcs and raw direction per slot
  always_comb
  begin
    for (int i = 0; i < `FETCH_NUM_SLOTS; i++)
    begin
      slot_pc[i]    = pc_base + 64'(4 * i);
      // jal always redirects, branches follow the counter
      slot_taken[i] = pdec[i].is_jal | (pdec[i].is_branch & bp_taken.taken[i]);
    end
  end

  ////////////////////////////////////////
  // slot validity and redirect
  ////////////////////////////////////////

  // walk slots in order and stop at the first taken one
  always_comb
  begin
    blocked     = 1'b0;
    redirect_pc = pc_seq;
    for (int i = 0; i < `FETCH_NUM_SLOTS; i++)
    begin
      // slot 0 is skipped when pc points at the upper half
      slot_valid[i] = !blocked && ((i != 0) || !pc_reg[2]);
      if (slot_valid[i] && slot_taken[i])
      begin
        blocked     = 1'b1;
        redirect_pc = pdec[i].target;
      end
    end
  end

  // packet assembly
  always_comb
  begin
    for (int i = 0; i < `FETCH_NUM_SLOTS; i++)
    begin
      push_packet[i].pc         = slot_pc[i];
      push_packet[i].npc        = slot_pc[i] + 64'd4;
      push_packet[i].valid      = slot_valid[i];
      push_packet[i].pred_taken = slot_valid[i] & slot_taken[i];
      // dead slots carry a nop so decode can ignore them safely
      push_packet[i].inst       = slot_valid[i] ? imem_data[32*i +: 32] : `FETCH_NOP_INST;
      push_packet[i].target     = push_packet[i].pred_taken ? pdec[i].target
                                                            : push_packet[i].npc;
    end
  end

  ////////////////////////////////////////
  // pc register
  ////////////////////////////////////////

  // rollback kills the word in flight this cycle
  assign push    = imem_valid & ~buf_full & ~rollback.en;
  assign pc_en   = push | rollback.en;
  assign next_pc = rollback.en ? rollback.pc : redirect_pc;  // rollback wins

  always_ff @(posedge clock)
  begin
    if (reset)
      pc_reg <= `FETCH_RESET_PC;
    else if (pc_en)
      pc_reg <= next_pc;          // holds while stalled so imem_addr stays put
  end

endmodule

//--- rtl/predecode.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module predecode (
  input  logic [`FETCH_NUM_SLOTS-1:0][63:0]            slot_pc,
  input  logic [63:0]                                  slot_word,
  output fetch_pkg::predecode_t [`FETCH_NUM_SLOTS-1:0] pdec
);

  localparam logic [6:0] OP_BRANCH = 7'b1100011;  // beq bne blt bge bltu bgeu
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  ////////////////////////////////////////
  // per slot decode
  ////////////////////////////////////////

  for (genvar i = 0; i < `FETCH_NUM_SLOTS; i++)
  begin : g_slot
    logic [31:0] inst;
    logic [6:0]  opcode;
    logic [63:0] b_imm;     // sign extended branch offset
    logic [63:0] j_imm;     // sign extended jal offset
    logic        is_branch;
    logic        is_jal;

    assign inst   = slot_word[32*i +: 32];
    assign opcode = inst[6:0];

    assign is_branch = (opcode == OP_BRANCH);
    assign is_jal    = (opcode == OP_JAL);

    // imm[12|10:5] in 31:25 and imm[4:1|11] in 11:7
    assign b_imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // imm[20|10:1|11|19:12] in 31:12
    assign j_imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign pdec[i].is_branch = is_branch;
    assign pdec[i].is_jal    = is_jal;
    // only meaningful when one of the flags is set
    assign pdec[i].target    = slot_pc[i] + (is_jal ? j_imm : b_imm);
  end

endmodule

//--- rtl/branch_predictor.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module branch_predictor (
  input  logic                              clock,
  input  logic                              reset,
  input  logic [`FETCH_NUM_SLOTS-1:0][63:0] slot_pc,
  output fetch_pkg::bp_lookup_t             bp_taken,
  input  fetch_pkg::bp_resolve_t            resolve
);

  localparam int IDX_W = $clog2(`FETCH_BP_ENTRIES);

  logic [1:0]       counters [`FETCH_BP_ENTRIES];  // 2-bit saturating
  logic [IDX_W-1:0] lookup_idx [`FETCH_NUM_SLOTS];
  logic [IDX_W-1:0] upd_idx;
  logic [1:0]       upd_cnt;                      // counter being trained
  logic [1:0]       upd_next;

  ////////////////////////////////////////
  // lookup
  ////////////////////////////////////////

  // bits 1:0 are always zero for rv64 without compressed
  always_comb
  begin
    for (int i = 0; i < `FETCH_NUM_SLOTS; i++)
    begin
      lookup_idx[i]     = slot_pc[i][IDX_W+1:2];
      bp_taken.taken[i] = counters[lookup_idx[i]][1];  // msb is the direction
    end
  end

  ////////////////////////////////////////
  // update
  ////////////////////////////////////////

  assign upd_idx = resolve.pc[IDX_W+1:2];
  assign upd_cnt = counters[upd_idx];

  // saturate at 00 and 11
  always_comb
  begin
    upd_next = upd_cnt;
    if (resolve.taken && (upd_cnt != 2'b11))
      upd_next = upd_cnt + 2'b01;
    else if (!resolve.taken && (upd_cnt != 2'b00))
      upd_next = upd_cnt - 2'b01;
  end

  // no bypass so lookups see a resolve one edge later
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int e = 0; e < `FETCH_BP_ENTRIES; e++)
        counters[e] <= 2'b01;   // weakly not taken
    end
    else if (resolve.valid)
    begin
      counters[upd_idx] <= upd_next;
    end
  end

endmodule

//--- rtl/fetch_buffer.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_buffer (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     flush,        // drop everything on rollback
  input  logic                     push,
  input  fetch_pkg::fetch_packet_t push_packet,
  output logic                     full,
  output fetch_pkg::fetch_packet_t out_packet,
  output logic                     out_valid,
  input  logic                     out_ready
);

  import fetch_pkg::*;

  localparam int               DEPTH = `FETCH_BUF_DEPTH;
  localparam int               PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W-1:0] LAST  = PTR_W'(DEPTH - 1);

  fetch_packet_t    mem [DEPTH];  // payload only
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;        // one extra bit to tell full from empty
  logic             do_push;
  logic             do_pop;

  assign full       = (count == (PTR_W+1)'(DEPTH));
  assign out_valid  = (count != '0);
  assign out_packet = mem[rd_ptr];  // head entry

  assign do_push = push & ~full;
  assign do_pop  = out_valid & out_ready;

  ////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (reset || flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      // push and pop together leave count alone
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (do_push)
      mem[wr_ptr] <= push_packet;
  end

endmodule

//--- rtl/fetch_top.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_top (
  input  logic                     clock,
  input  logic                     reset,
  output logic [63:0]              imem_addr,
  input  logic [63:0]              imem_data,
  input  logic                     imem_valid,
  input  fetch_pkg::bp_resolve_t   resolve,
  input  fetch_pkg::rollback_t     rollback,
  output fetch_pkg::fetch_packet_t out_packet,
  output logic                     out_valid,
  input  logic                     out_ready
);

  import fetch_pkg::*;

  logic [`FETCH_NUM_SLOTS-1:0][63:0] slot_pc;
  logic [63:0]                       slot_word;
  predecode_t [`FETCH_NUM_SLOTS-1:0] pdec;
  bp_lookup_t                        bp_taken;
  logic                              buf_full;
  logic                              push;
  fetch_packet_t                     push_packet;

  ////////////////////////////////////////
  // pc control and packet build
  ////////////////////////////////////////

  fetch_stage i_stage (
    .clock       (clock),
    .reset       (reset),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .imem_valid  (imem_valid),
    .rollback    (rollback),
    .slot_pc     (slot_pc),
    .slot_word   (slot_word),
    .pdec        (pdec),
    .bp_taken    (bp_taken),
    .buf_full    (buf_full),
    .push        (push),
    .push_packet (push_packet)
  );

  predecode i_predecode (
    .slot_pc   (slot_pc),
    .slot_word (slot_word),
    .pdec      (pdec)
  );

  branch_predictor i_bp (
    .clock    (clock),
    .reset    (reset),
    .slot_pc  (slot_pc),
    .bp_taken (bp_taken),
    .resolve  (resolve)      // straight from execute
  );

  ////////////////////////////////////////
  // decode side queue
  ////////////////////////////////////////

  fetch_buffer i_buffer (
    .clock       (clock),
    .reset       (reset),
    .flush       (rollback.en),
    .push        (push),
    .push_packet (push_packet),
    .full        (buf_full),
    .out_packet  (out_packet),
    .out_valid   (out_valid),
    .out_ready   (out_ready)
  );

endmodule

//--- verif/fetch_checker.sv
`timescale 1ns/10ps

module fetch_checker (
  input logic                     clock,
  input logic                     reset,
  input logic [63:0]              imem_addr,
  input fetch_pkg::rollback_t     rollback,
  input logic                     buf_full,
  input logic                     out_valid,
  input fetch_pkg::fetch_packet_t push_packet
);

  import fetch_pkg::*;

  fetch_slot_t slot0;
  fetch_slot_t slot1;

  assign slot0 = push_packet[0];
  assign slot1 = push_packet[1];

  ////////////////////////////////////////
  // reset and address
  ////////////////////////////////////////

  a_idle_after_reset: assert property (@(posedge clock) reset |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  a_addr_aligned: assert property (@(posedge clock) disable iff (reset)
    imem_addr[2:0] == 3'b000)
    else $error("imem_addr not 8-byte aligned");

  // full buffer blocks the push, so the pc must hold
  a_addr_hold: assert property (@(posedge clock) disable iff (reset)
    (buf_full && !rollback.en) |=> $stable(imem_addr))
    else $error("imem_addr moved while the buffer was full");

  ////////////////////////////////////////
  // slot rules
  ////////////////////////////////////////

  a_taken_kills_slot1: assert property (@(posedge clock) disable iff (reset)
    (slot0.valid && slot0.pred_taken) |-> !slot1.valid)
    else $error("slot 1 valid behind a taken slot 0");

endmodule

bind fetch_top fetch_checker i_checker (
  .clock       (clock),
  .reset       (reset),
  .imem_addr   (imem_addr),
  .rollback    (rollback),
  .buf_full    (buf_full),
  .out_valid   (out_valid),
  .push_packet (push_packet)
);

//--- verif/fetch_tb.sv
`timescale 1ns/10ps
`include "fetch_params.svh"

module fetch_tb;

  import fetch_pkg::*;

  localparam int MEM_WORDS = 256;   // 1 KB of instruction memory, wraps
  localparam int TIMEOUT   = 50;    // cycles allowed for any single wait

  logic          clock;
  logic          reset;
  logic [63:0]   imem_addr;
  logic [63:0]   imem_data;
  logic          imem_valid;
  bp_resolve_t   resolve;
  rollback_t     rollback;
  fetch_packet_t out_packet;
  logic          out_valid;
  logic          out_ready;

  logic [31:0] mem [MEM_WORDS];
  logic [63:0] tgt [MEM_WORDS];                // direct target of each placed jump
  logic [1:0]  ref_cnt [`FETCH_BP_ENTRIES];    // model of the bimodal table
  logic [63:0] ref_pc;                         // model fetch pc
  logic        gap_mode;                       // randomize imem_valid while waiting
  integer      seed;
  int          errors;
  int          tests;
  int          failed;

  fetch_top i_dut (
    .clock      (clock),
    .reset      (reset),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .imem_valid (imem_valid),
    .resolve    (resolve),
    .rollback   (rollback),
    .out_packet (out_packet),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  // memory answers in the same cycle, low word at the aligned address
  assign imem_data = {mem[{imem_addr[9:3], 1'b1}], mem[{imem_addr[9:3], 1'b0}]};

  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  ////////////////////////////////////////
  // memory setup and model
  ////////////////////////////////////////

  // addi x1,x0,<word index> everywhere
  task automatic fill_straight();
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem[i] = {12'(i), 5'd0, 3'b000, 5'd1, 7'b0010011};
      tgt[i] = '0;
    end
  endtask

  task automatic place_jal(input logic [63:0] addr, input logic [63:0] target);
    logic [63:0] off;
    off = target - addr;
    mem[addr[9:2]] = {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};  // jal x0
    tgt[addr[9:2]] = target;
  endtask

  task automatic place_branch(input logic [63:0] addr, input logic [63:0] target);
    logic [63:0] off;
    off = target - addr;
    // bne x1,x0
    mem[addr[9:2]] = {off[12], off[10:5], 5'd0, 5'd1, 3'b001, off[4:1], off[11], 7'b1100011};
    tgt[addr[9:2]] = target;
  endtask

  // next packet expected at ref_pc, then ref_pc moves on
  task automatic model_next_packet(output fetch_packet_t pkt);
    logic [63:0] base;
    logic [63:0] spc;
    logic [63:0] next;
    logic [31:0] word;
    logic        hit;       // earlier slot already redirects
    logic        taken;
    base = {ref_pc[63:3], 3'b000};
    next = base + 64'd8;
    hit  = 1'b0;
    pkt  = '0;
    for (int i = 0; i < `FETCH_NUM_SLOTS; i++)
    begin
      spc   = base + 64'(4 * i);
      word  = mem[spc[9:2]];
      taken = (word[6:0] == 7'b1101111) ||
              ((word[6:0] == 7'b1100011) && ref_cnt[spc[7:2]][1]);
      pkt[i].pc         = spc;
      pkt[i].npc        = spc + 64'd4;
      pkt[i].valid      = !hit && !((i == 0) && ref_pc[2]);
      pkt[i].pred_taken = pkt[i].valid && taken;
      pkt[i].inst       = pkt[i].valid ? word : `FETCH_NOP_INST;
      pkt[i].target     = pkt[i].pred_taken ? tgt[spc[9:2]] : pkt[i].npc;
      if (pkt[i].pred_taken)
      begin
        hit  = 1'b1;
        next = pkt[i].target;
      end
    end
    ref_pc = next;
  endtask

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_field(input string field, input int slot,
                             input logic [63:0] exp, input logic [63:0] got);
    if (exp !== got)
    begin
      $display("FAIL %0t out_packet[%0d].%s expected %h got %h",
               $time, slot, field, exp, got);
      errors++;
    end
  endtask

  task automatic compare_packet(input fetch_packet_t exp, input fetch_packet_t got);
    for (int i = 0; i < `FETCH_NUM_SLOTS; i++)
    begin
      check_field("pc", i, exp[i].pc, got[i].pc);
      check_field("npc", i, exp[i].npc, got[i].npc);
      check_field("inst", i, 64'(exp[i].inst), 64'(got[i].inst));
      check_field("target", i, exp[i].target, got[i].target);
      check_field("pred_taken", i, 64'(exp[i].pred_taken), 64'(got[i].pred_taken));
      check_field("valid", i, 64'(exp[i].valid), 64'(got[i].valid));
    end
  endtask

  task automatic compare_addr(input logic [63:0] exp);
    if (imem_addr !== exp)
    begin
      $display("FAIL %0t imem_addr expected %h got %h", $time, exp, imem_addr);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // drivers, all on the falling edge
  ////////////////////////////////////////

  task automatic do_reset();
    reset      = 1'b1;
    imem_valid = 1'b0;
    resolve    = '0;
    rollback   = '0;
    out_ready  = 1'b1;
    gap_mode   = 1'b0;
    for (int i = 0; i < `FETCH_BP_ENTRIES; i++)
      ref_cnt[i] = 2'b01;     // weakly not taken
    repeat (5) @(negedge clock);
    reset  = 1'b0;
    ref_pc = `FETCH_RESET_PC;
  endtask

  // waits for a head packet with ready high and checks it against the model
  task automatic expect_packet(input string name);
    fetch_packet_t exp;
    int            waited;
    waited = 0;
    do
    begin
      @(negedge clock);
      if (gap_mode)
        imem_valid = (($random(seed) & 32'sd3) != 0);  // about one cycle in four idle
      waited++;
    end
    while (!out_valid && (waited < TIMEOUT));
    if (!out_valid)
    begin
      $display("timeout in %s, no packet arrived within %0d cycles", name, TIMEOUT);
      errors++;
    end
    else
    begin
      model_next_packet(exp);
      compare_packet(exp, out_packet);
    end
  endtask

  task automatic send_resolve(input logic [63:0] pc, input logic taken);
    logic [1:0] c;
    resolve = {1'b1, pc, taken};
    @(negedge clock);
    resolve.valid = 1'b0;
    c = ref_cnt[pc[7:2]];
    if (taken && (c != 2'b11))
      c = c + 2'b01;
    else if (!taken && (c != 2'b00))
      c = c - 2'b01;
    ref_cnt[pc[7:2]] = c;
  endtask

  task automatic redirect(input logic [63:0] pc);
    rollback = {1'b1, pc};
    @(negedge clock);
    rollback.en = 1'b0;
    ref_pc      = pc;       // everything buffered is gone
  endtask

  // one packet from pc with memory otherwise idle
  task automatic fetch_one(input logic [63:0] pc);
    redirect(pc);
    imem_valid = 1'b1;
    expect_packet("predictor");
    imem_valid = 1'b0;
  endtask

  task automatic finish_test(input string name, input int start);
    tests++;
    if (errors != start)
    begin
      failed++;
      $display("test %s: %0d error(s)", name, errors - start);
    end
    else
      $display("test %s: passed", name);
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_sequential();
    int start;
    start = errors;
    fill_straight();
    do_reset();
    imem_valid = 1'b1;
    repeat (6) expect_packet("sequential");
    finish_test("sequential", start);
  endtask

  task automatic test_jal();
    int start;
    start = errors;
    fill_straight();
    place_jal(64'h8, 64'h44);           // target in the upper half of a word
    do_reset();
    imem_valid = 1'b1;
    repeat (4) expect_packet("jal");
    finish_test("jal", start);
  endtask

  task automatic test_predictor();
    int start;
    start = errors;
    fill_straight();
    place_branch(64'h10, 64'h80);
    do_reset();
    fetch_one(64'h10);                  // 01 so not taken
    send_resolve(64'h10, 1'b1);
    send_resolve(64'h10, 1'b1);
    fetch_one(64'h10);                  // 11 now, slot 1 dropped
    send_resolve(64'h10, 1'b0);
    send_resolve(64'h10, 1'b0);
    fetch_one(64'h10);                  // back to 01
    finish_test("predictor", start);
  endtask

  task automatic test_backpressure();
    fetch_packet_t scratch;
    logic [63:0]   saved_pc;
    logic [63:0]   hold_addr;
    int            start;
    int            waited;
    start     = errors;
    fill_straight();
    do_reset();
    // address that fetch must stall on once the buffer is full
    saved_pc  = ref_pc;
    for (int k = 0; k < `FETCH_BUF_DEPTH; k++)
      model_next_packet(scratch);
    hold_addr = {ref_pc[63:3], 3'b000};
    ref_pc    = saved_pc;
    out_ready  = 1'b0;
    imem_valid = 1'b1;
    waited     = 0;
    while ((imem_addr !== hold_addr) && (waited < TIMEOUT))
    begin
      @(negedge clock);
      waited++;
    end
    if (imem_addr !== hold_addr)
    begin
      $display("timeout in backpressure, fetch never stalled at %h", hold_addr);
      errors++;
    end
    for (int k = 0; k < 4; k++)
    begin
      @(negedge clock);
      compare_addr(hold_addr);
    end
    // oldest packet is already at the head, ready would pop it on the next edge
    if (!out_valid)
    begin
      $display("backpressure stall left the buffer empty");
      errors++;
    end
    else
    begin
      model_next_packet(scratch);
      compare_packet(scratch, out_packet);
    end
    out_ready = 1'b1;
    repeat (`FETCH_BUF_DEPTH + 1) expect_packet("backpressure");
    finish_test("backpressure", start);
  endtask

  task automatic test_rollback();
    int start;
    start = errors;
    fill_straight();
    do_reset();
    imem_valid = 1'b1;
    repeat (2) expect_packet("rollback");
    out_ready = 1'b0;
    repeat (3) @(negedge clock);      // let a few packets pile up
    redirect(64'h44);
    out_ready = 1'b1;
    repeat (3) expect_packet("rollback");
    finish_test("rollback", start);
  endtask

  task automatic test_gaps();
    int start;
    start = errors;
    fill_straight();
    place_jal(64'h30, 64'h4);           // loop back into the first word
    do_reset();
    imem_valid = 1'b1;
    gap_mode   = 1'b1;
    repeat (12) expect_packet("gaps");
    gap_mode = 1'b0;
    finish_test("gaps", start);
  endtask

  initial
  begin
    seed       = 76319;
    errors     = 0;
    tests      = 0;
    failed     = 0;
    reset      = 1'b1;
    imem_valid = 1'b0;
    resolve    = '0;
    rollback   = '0;
    out_ready  = 1'b1;
    gap_mode   = 1'b0;
    ref_pc     = '0;
    test_sequential();
    test_jal();
    test_predictor();
    test_backpressure();
    test_rollback();
    test_gaps();
    $display("tests run %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_stage.sv
rtl/predecode.sv
rtl/branch_predictor.sv
rtl/fetch_buffer.sv
rtl/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build the fetch front end testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f filelist.f --top-module fetch_tb -o fetch_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/fetch_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
